//--- f8_alu.sv
// arithmetic, logic and shift unit
// 8-bit ops on the low bytes, word ops on all 16 bits
`default_nettype none

module f8_alu import f8_pkg::*;
(
	input  alu_op_t                op,
	input  wire logic [WORD_W-1:0] a,
	input  wire logic [WORD_W-1:0] b,
	output logic      [WORD_W-1:0] result,
	output flags_t                 flags_out
);

	logic [BYTE_W-1:0] res8;
	logic [WORD_W-1:0] res16;
	logic              carry;
	logic              wide;

	always_comb
	begin
		res8  = '0;
		res16 = '0;
		carry = 1'b0;
		wide  = 1'b0;
		case (op)
			ALU_ADD:
				{carry, res8} = {1'b0, a[7:0]} + {1'b0, b[7:0]};
			// carry set means no borrow
			ALU_SUB:
				{carry, res8} = {1'b0, a[7:0]} + {1'b0, ~b[7:0]} + 9'd1;
			ALU_AND:
				res8 = a[7:0] & b[7:0];
			ALU_OR:
				res8 = a[7:0] | b[7:0];
			ALU_XOR:
				res8 = a[7:0] ^ b[7:0];
			ALU_INC:
				{carry, res8} = {1'b0, a[7:0]} + 9'd1;
			ALU_SRL:
			begin
				res8  = {1'b0, a[7:1]};
				carry = a[0];
			end
			ALU_PASSW:
			begin
				wide  = 1'b1;
				res16 = a;
			end
			ALU_ADDW:
			begin
				wide = 1'b1;
				{carry, res16} = {1'b0, a} + {1'b0, b};
			end
			default:
				res8 = b[7:0];
		endcase
	end

	assign result      = wide ? res16 : {{(WORD_W-BYTE_W){1'b0}}, res8};
	assign flags_out.c = carry;
	assign flags_out.z = wide ? (res16 == '0) : (res8 == '0);
	assign flags_out.n = wide ? res16[WORD_W-1] : res8[BYTE_W-1];

endmodule

`default_nettype wire

//--- f8_core.sv
// single-cycle f8 core, top level
// flag register, operand muxes and data-port drive
// one instruction retires per clock edge
`default_nettype none

module f8_core import f8_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              reset,
	output logic      [ADDR_W-1:0] iread_addr,
	input  wire logic [INST_W-1:0] iread_data,
	output logic      [ADDR_W-1:0] dread_addr,
	input  wire logic [WORD_W-1:0] dread_data,
	output dwrite_t                dwrite,
	output logic                   trap
);

	decode_t           dec;
	flags_t            flags;
	flags_t            alu_flags;
	logic [WORD_W-1:0] x;
	logic [WORD_W-1:0] y;
	logic [WORD_W-1:0] op_a;
	logic [WORD_W-1:0] op_b;
	logic [WORD_W-1:0] alu_result;
	logic [ADDR_W-1:0] pc;
	logic              halt;

	f8_decode u_decode (
		.opcode (iread_data[7:0]),
		.dec    (dec)
	);

	f8_flow u_flow (
		.clk   (clk),
		.reset (reset),
		.dec   (dec),
		.flags (flags),
		.inst  (iread_data),
		.pc    (pc),
		.trap  (trap)
	);

	assign iread_addr = pc;
	assign halt       = trap || reset;

	// direct operand address only when memory feeds the alu
	assign dread_addr = (dec.src_b == SRC2_MEM8) ? iread_data[23:8] : '0;

	always_comb
	begin
		case (dec.src_a)
			SRC_Y:     op_a = y;
			SRC_IMM8:  op_a = {8'h00, iread_data[15:8]};
			SRC_IMM16: op_a = iread_data[23:8];
			default:   op_a = {8'h00, x[7:0]};
		endcase

		case (dec.src_b)
			SRC2_IMM8:  op_b = {8'h00, iread_data[15:8]};
			SRC2_IMM16: op_b = iread_data[23:8];
			SRC2_MEM8:  op_b = {8'h00, dread_data[7:0]};
			default:    op_b = '0;
		endcase
	end

	f8_alu u_alu (
		.op        (dec.alu_op),
		.a         (op_a),
		.b         (op_b),
		.result    (alu_result),
		.flags_out (alu_flags)
	);

	f8_regfile u_regfile (
		.clk     (clk),
		.reset   (reset),
		.wr_addr (dec.reg_addr),
		.wr_data (alu_result),
		.wr_en   (halt ? 2'b00 : dec.reg_we),
		.x       (x),
		.y       (y)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else if (!trap)
		begin
			if (dec.upd_c)
				flags.c <= alu_flags.c;
			if (dec.upd_z)
				flags.z <= alu_flags.z;
			if (dec.upd_n)
				flags.n <= alu_flags.n;
		end
	end

	// xl stores use only the low byte of the result
	assign dwrite.addr = iread_data[23:8];
	assign dwrite.data = alu_result;
	assign dwrite.en   = halt ? 2'b00 : dec.mem_we;

endmodule

`default_nettype wire

//--- f8_decode.sv
// instruction decoder
// maps the opcode byte onto the control word used by the datapath
`default_nettype none

module f8_decode import f8_pkg::*;
(
	input  wire logic [7:0] opcode,
	output decode_t         dec
);

	always_comb
	begin
		// anything not listed behaves as a one-byte nop
		dec.alu_op   = ALU_PASS;
		dec.src_a    = SRC_XL;
		dec.src_b    = SRC2_NONE;
		dec.reg_addr = 1'b0;
		dec.reg_we   = 2'b00;
		dec.mem_we   = 2'b00;
		dec.upd_c    = 1'b0;
		dec.upd_z    = 1'b0;
		dec.upd_n    = 1'b0;
		dec.branch   = BR_NONE;
		dec.length   = 2'd1;
		dec.is_trap  = 1'b0;

		case (opcode_t'(opcode))
			LD_XL_IMMD, LD_XL_DIR:
			begin
				dec.src_b  = (opcode_t'(opcode) == LD_XL_DIR) ? SRC2_MEM8 : SRC2_IMM8;
				dec.reg_we = 2'b01;
				dec.upd_z  = 1'b1;
				dec.upd_n  = 1'b1;
				dec.length = (opcode_t'(opcode) == LD_XL_DIR) ? 2'd3 : 2'd2;
			end
			ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD:
			begin
				case (opcode_t'(opcode))
					ADD_XL_IMMD: dec.alu_op = ALU_ADD;
					SUB_XL_IMMD: dec.alu_op = ALU_SUB;
					AND_XL_IMMD: dec.alu_op = ALU_AND;
					OR_XL_IMMD:  dec.alu_op = ALU_OR;
					default:     dec.alu_op = ALU_XOR;
				endcase
				dec.src_b  = SRC2_IMM8;
				dec.reg_we = 2'b01;
				// logic ops leave carry alone
				dec.upd_c  = (opcode_t'(opcode) == ADD_XL_IMMD) ||
					(opcode_t'(opcode) == SUB_XL_IMMD);
				dec.upd_z  = 1'b1;
				dec.upd_n  = 1'b1;
				dec.length = 2'd2;
			end
			ADD_XL_DIR, INC_XL, SRL_XL:
			begin
				dec.alu_op = (opcode_t'(opcode) == INC_XL) ? ALU_INC :
					(opcode_t'(opcode) == SRL_XL) ? ALU_SRL : ALU_ADD;
				dec.src_b  = (opcode_t'(opcode) == ADD_XL_DIR) ? SRC2_MEM8 : SRC2_NONE;
				dec.reg_we = 2'b01;
				dec.upd_c  = 1'b1;
				dec.upd_z  = 1'b1;
				dec.upd_n  = 1'b1;
				dec.length = (opcode_t'(opcode) == ADD_XL_DIR) ? 2'd3 : 2'd1;
			end
			LDW_Y_IMMD, ADDW_Y_IMMD:
			begin
				dec.alu_op   = (opcode_t'(opcode) == ADDW_Y_IMMD) ? ALU_ADDW : ALU_PASSW;
				dec.src_a    = (opcode_t'(opcode) == ADDW_Y_IMMD) ? SRC_Y : SRC_IMM16;
				dec.src_b    = SRC2_IMM16;
				dec.reg_addr = 1'b1;
				dec.reg_we   = 2'b11;
				dec.upd_c    = (opcode_t'(opcode) == ADDW_Y_IMMD);
				dec.upd_z    = 1'b1;
				dec.upd_n    = 1'b1;
				dec.length   = 2'd3;
			end
			LDW_X_Y:
			begin
				dec.alu_op = ALU_PASSW;
				dec.src_a  = SRC_Y;
				dec.reg_we = 2'b11;
				dec.upd_z  = 1'b1;
				dec.upd_n  = 1'b1;
			end
			LD_DIR_XL, LDW_DIR_Y:
			begin
				// stores route the register through the alu unchanged
				dec.alu_op = ALU_PASSW;
				dec.src_a  = (opcode_t'(opcode) == LDW_DIR_Y) ? SRC_Y : SRC_XL;
				dec.mem_we = (opcode_t'(opcode) == LDW_DIR_Y) ? 2'b11 : 2'b01;
				dec.length = 2'd3;
			end
			JP_IMMD:
			begin
				dec.branch = BR_ABS;
				dec.length = 2'd3;
			end
			JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D:
			begin
				case (opcode_t'(opcode))
					JRZ_D:   dec.branch = BR_REL_Z;
					JRNZ_D:  dec.branch = BR_REL_NZ;
					JRC_D:   dec.branch = BR_REL_C;
					JRNC_D:  dec.branch = BR_REL_NC;
					default: dec.branch = BR_REL;
				endcase
				dec.length = 2'd2;
			end
			TRAP:
				dec.is_trap = 1'b1;
			default:
				dec.length = 2'd1;
		endcase
	end

endmodule

`default_nettype wire

//--- f8_flow.sv
// program counter and next-pc selection
// branch conditions, halt once a trap is reached
`default_nettype none

module f8_flow import f8_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              reset,
	input  decode_t                dec,
	input  flags_t                 flags,
	input  wire logic [INST_W-1:0] inst,
	output logic      [ADDR_W-1:0] pc,
	output logic                   trap
);

	logic [ADDR_W-1:0] next_pc;
	logic [ADDR_W-1:0] rel_target;
	logic [ADDR_W-1:0] seq_pc;
	logic              rel_taken;
	logic              trap_q;

	// relative to the jump's own address
	assign rel_target = pc + {{(ADDR_W-BYTE_W){inst[15]}}, inst[15:8]};
	assign seq_pc     = pc + {{(ADDR_W-2){1'b0}}, dec.length};

	always_comb
	begin
		case (dec.branch)
			BR_REL:    rel_taken = 1'b1;
			BR_REL_Z:  rel_taken = flags.z;
			BR_REL_NZ: rel_taken = !flags.z;
			BR_REL_C:  rel_taken = flags.c;
			BR_REL_NC: rel_taken = !flags.c;
			default:   rel_taken = 1'b0;
		endcase

		if (trap)
			next_pc = pc;
		else if (dec.branch == BR_ABS)
			next_pc = inst[23:8];
		else if (rel_taken)
			next_pc = rel_target;
		else
			next_pc = seq_pc;
	end

	// trap is visible while the TRAP is addressed and sticks after it
	assign trap = trap_q || (dec.is_trap && !reset);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc     <= RESET_PC;
			trap_q <= 1'b0;
		end
		else
		begin
			pc     <= next_pc;
			trap_q <= trap;
		end
	end

endmodule

`default_nettype wire

//--- f8_pkg.sv
// shared definitions for the reduced f8 core
// widths, reset vector, opcode and ALU-operation encodings
// flag word, decoded control word and data-write bundle
`default_nettype none

package f8_pkg;

	localparam int ADDR_W = 16;
	localparam int WORD_W = 16;
	localparam int BYTE_W = 8;
	// opcode in the low byte, operand bytes above it
	localparam int INST_W = 24;
	localparam logic [ADDR_W-1:0] RESET_PC = 16'h4000;

	typedef enum logic [7:0] {
		TRAP        = 8'h00,
		NOP         = 8'h01,
		LD_XL_IMMD  = 8'h10,
		LD_XL_DIR   = 8'h11,
		ADD_XL_IMMD = 8'h20,
		SUB_XL_IMMD = 8'h21,
		AND_XL_IMMD = 8'h22,
		OR_XL_IMMD  = 8'h23,
		XOR_XL_IMMD = 8'h24,
		ADD_XL_DIR  = 8'h25,
		INC_XL      = 8'h30,
		SRL_XL      = 8'h31,
		LDW_Y_IMMD  = 8'h40,
		ADDW_Y_IMMD = 8'h41,
		LDW_X_Y     = 8'h42,
		LD_DIR_XL   = 8'h50,
		LDW_DIR_Y   = 8'h51,
		JP_IMMD     = 8'h60,
		JR_D        = 8'h61,
		JRZ_D       = 8'h62,
		JRNZ_D      = 8'h63,
		JRC_D       = 8'h64,
		JRNC_D      = 8'h65
	} opcode_t;

	// byte ops work on the low bytes, PASS takes operand b
	// PASSW and ADDW are full width, PASSW takes operand a
	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC,
		ALU_SRL,
		ALU_PASSW,
		ALU_ADDW
	} alu_op_t;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
	} flags_t;

	typedef enum logic [1:0] {SRC_XL, SRC_Y, SRC_IMM8, SRC_IMM16} operand_src_t;
	typedef enum logic [1:0] {SRC2_NONE, SRC2_IMM8, SRC2_IMM16, SRC2_MEM8} operand2_src_t;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_ABS,
		BR_REL,
		BR_REL_Z,
		BR_REL_NZ,
		BR_REL_C,
		BR_REL_NC
	} branch_t;

	typedef struct packed {
		alu_op_t       alu_op;
		operand_src_t  src_a;
		operand2_src_t src_b;
		logic          reg_addr;  // 0 is x, 1 is y
		logic [1:0]    reg_we;
		logic [1:0]    mem_we;
		logic          upd_c;
		logic          upd_z;
		logic          upd_n;
		branch_t       branch;
		logic [1:0]    length;
		logic          is_trap;
	} decode_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] data;
		logic [1:0]        en;
	} dwrite_t;

endpackage

`default_nettype wire

//--- f8_regfile.sv
// x and y registers, written a byte at a time
`default_nettype none

module f8_regfile import f8_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              wr_addr,
	input  wire logic [WORD_W-1:0] wr_data,
	input  wire logic [1:0]        wr_en,
	output logic      [WORD_W-1:0] x,
	output logic      [WORD_W-1:0] y
);

	logic [1:0] x_we;
	logic [1:0] y_we;

	assign x_we = wr_addr ? 2'b00 : wr_en;
	assign y_we = wr_addr ? wr_en : 2'b00;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			x <= '0;
			y <= '0;
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (x_we[i])
					x[i*BYTE_W +: BYTE_W] <= wr_data[i*BYTE_W +: BYTE_W];
				if (y_we[i])
					y[i*BYTE_W +: BYTE_W] <= wr_data[i*BYTE_W +: BYTE_W];
			end
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the f8 core testbench with Verilator
rm -f sim.log
verilator --binary --timing --top-module tb_f8 -f vlog.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_f8 > sim.log 2>&1
grep -qx "NO ERRORS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- tb_f8.sv
// testbench for the f8 core
// byte memory, random program generator, reference model and comparison
`default_nettype none

module tb_f8 import f8_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic              clk;
	logic              reset;
	logic [ADDR_W-1:0] iread_addr;
	logic [INST_W-1:0] iread_data;
	logic [ADDR_W-1:0] dread_addr;
	logic [WORD_W-1:0] dread_data;
	dwrite_t           dwrite;
	logic              trap;

	logic [7:0]  mem [0:65535];
	logic [7:0]  m_mem [0:65535];
	logic [15:0] m_x, m_y, m_pc;
	logic        m_c, m_z, m_n;
	logic [1:0]  exp_en;
	logic [15:0] exp_addr, exp_data;
	logic [15:0] exp_raddr;
	logic        exp_trap;
	int          errors, cycles, trap_cycles;
	logic        active;

	f8_core u_f8_core (
		.clk        (clk),
		.reset      (reset),
		.iread_addr (iread_addr),
		.iread_data (iread_data),
		.dread_addr (dread_addr),
		.dread_data (dread_data),
		.dwrite     (dwrite),
		.trap       (trap)
	);

	assign iread_data = {mem[iread_addr + 16'd2], mem[iread_addr + 16'd1], mem[iread_addr]};
	assign dread_data = {mem[dread_addr + 16'd1], mem[dread_addr]};

	always @(posedge clk)
	begin
		if (dwrite.en[0])
			mem[dwrite.addr] <= dwrite.data[7:0];
		if (dwrite.en[1])
			mem[dwrite.addr + 16'd1] <= dwrite.data[15:8];
	end

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [15:0] inst_length(opcode_t op);
		case (op)
			NOP, INC_XL, SRL_XL, LDW_X_Y, TRAP: return 16'd1;
			LD_XL_IMMD, ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD,
			XOR_XL_IMMD, JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D: return 16'd2;
			default: return 16'd3;
		endcase
	endfunction

	// byte result into xl with 8-bit z and n
	function automatic void put_xl(logic [7:0] v);
		m_x[7:0] = v;
		m_z = (v == 8'h00);
		m_n = v[7];
	endfunction

	// architectural model, one instruction per call
	function automatic void model_step();
		logic [23:0] inst;
		opcode_t     op;
		logic [7:0]  imm8;
		logic [15:0] imm16;
		logic [8:0]  s9;
		logic [16:0] s17;
		logic        take;
		inst = {m_mem[m_pc + 16'd2], m_mem[m_pc + 16'd1], m_mem[m_pc]};
		op = opcode_t'(inst[7:0]);
		imm8 = inst[15:8];
		imm16 = inst[23:8];
		take = 1'b0;
		exp_en = 2'b00;
		exp_trap = 1'b0;
		exp_raddr = 16'h0000;
		case (op)
			TRAP:
			begin
				exp_trap = 1'b1;
				return;
			end
			LD_XL_IMMD: put_xl(imm8);
			LD_XL_DIR:
			begin
				exp_raddr = imm16;
				put_xl(m_mem[imm16]);
			end
			ADD_XL_IMMD, ADD_XL_DIR:
			begin
				if (op == ADD_XL_DIR)
					exp_raddr = imm16;
				s9 = {1'b0, m_x[7:0]} + {1'b0, (op == ADD_XL_DIR) ? m_mem[imm16] : imm8};
				m_c = s9[8];
				put_xl(s9[7:0]);
			end
			SUB_XL_IMMD:
			begin
				m_c = (m_x[7:0] >= imm8);
				put_xl(m_x[7:0] - imm8);
			end
			AND_XL_IMMD: put_xl(m_x[7:0] & imm8);
			OR_XL_IMMD: put_xl(m_x[7:0] | imm8);
			XOR_XL_IMMD: put_xl(m_x[7:0] ^ imm8);
			INC_XL:
			begin
				m_c = (m_x[7:0] == 8'hff);
				put_xl(m_x[7:0] + 8'd1);
			end
			SRL_XL:
			begin
				m_c = m_x[0];
				put_xl({1'b0, m_x[7:1]});
			end
			LDW_Y_IMMD, ADDW_Y_IMMD, LDW_X_Y:
			begin
				if (op == LDW_X_Y)
					s17 = {1'b0, m_y};
				else if (op == ADDW_Y_IMMD)
					s17 = {1'b0, m_y} + {1'b0, imm16};
				else
					s17 = {1'b0, imm16};
				if (op == ADDW_Y_IMMD)
					m_c = s17[16];
				if (op == LDW_X_Y)
					m_x = s17[15:0];
				else
					m_y = s17[15:0];
				m_z = (s17[15:0] == 16'h0000);
				m_n = s17[15];
			end
			LD_DIR_XL:
			begin
				exp_en = 2'b01;
				exp_addr = imm16;
				exp_data = {8'h00, m_x[7:0]};
				m_mem[imm16] = m_x[7:0];
			end
			LDW_DIR_Y:
			begin
				exp_en = 2'b11;
				exp_addr = imm16;
				exp_data = m_y;
				m_mem[imm16] = m_y[7:0];
				m_mem[imm16 + 16'd1] = m_y[15:8];
			end
			JR_D: take = 1'b1;
			JRZ_D: take = m_z;
			JRNZ_D: take = !m_z;
			JRC_D: take = m_c;
			JRNC_D: take = !m_c;
			default: ;
		endcase
		if (op == JP_IMMD)
			m_pc = imm16;
		else if (take)
			m_pc = m_pc + {{8{imm8[7]}}, imm8};
		else
			m_pc = m_pc + inst_length(op);
	endfunction

	// compare against the model before each retiring edge
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (active && !reset)
		begin
			if (iread_addr !== m_pc)
			begin
				$display("FAILED %0t iread_addr expected %h got %h", $time, m_pc, iread_addr);
				errors = errors + 1;
			end
			model_step();
			if (trap !== exp_trap)
			begin
				$display("FAILED %0t trap expected %b got %b", $time, exp_trap, trap);
				errors = errors + 1;
			end
			if (dread_addr !== exp_raddr)
			begin
				$display("FAILED %0t dread_addr expected %h got %h", $time, exp_raddr,
					dread_addr);
				errors = errors + 1;
			end
			if (dwrite.en !== exp_en)
			begin
				$display("FAILED %0t dwrite.en expected %b got %b", $time, exp_en, dwrite.en);
				errors = errors + 1;
			end
			else if (exp_en != 2'b00 && dwrite.addr !== exp_addr)
			begin
				$display("FAILED %0t dwrite.addr expected %h got %h", $time, exp_addr,
					dwrite.addr);
				errors = errors + 1;
			end
			else if ((exp_en == 2'b01 && dwrite.data[7:0] !== exp_data[7:0]) ||
				(exp_en == 2'b11 && dwrite.data !== exp_data))
			begin
				$display("FAILED %0t dwrite.data expected %h got %h", $time, exp_data,
					dwrite.data);
				errors = errors + 1;
			end
			if (exp_trap)
				trap_cycles = trap_cycles + 1;
		end
	end

	initial
	begin
		opcode_t     choices [0:21];
		opcode_t     ops [0:199];
		logic [15:0] starts [0:200];
		logic [15:0] a;
		logic [15:0] dir;
		int          n;
		int          j;
		reset = 1'b1;
		active = 1'b0;
		errors = 0;
		cycles = 0;
		trap_cycles = 0;
		void'($urandom(32'hb675fb2f));
		choices = '{NOP, LD_XL_IMMD, LD_XL_DIR, ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD,
			OR_XL_IMMD, XOR_XL_IMMD, ADD_XL_DIR, INC_XL, SRL_XL, LDW_Y_IMMD, ADDW_Y_IMMD,
			LDW_X_Y, LD_DIR_XL, LDW_DIR_Y, JP_IMMD, JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D};
		for (int i = 0; i < 65536; i++)
		begin
			a = 16'(i);
			mem[i] = a[7:0] ^ a[15:8] ^ 8'h5a;
		end
		// lay out the instruction starts first so jumps can target them
		a = RESET_PC;
		for (int i = 0; i < 200; i++)
		begin
			ops[i] = choices[$urandom % 22];
			starts[i] = a;
			a = a + inst_length(ops[i]);
		end
		starts[200] = a;
		for (int i = 0; i < 200; i++)
		begin
			mem[starts[i]] = ops[i];
			mem[starts[i] + 16'd1] = 8'($urandom);
			mem[starts[i] + 16'd2] = 8'($urandom);
			dir = 16'h0100 + 16'($urandom % 256);
			n = 0;
			while (i + 1 + n <= 200 && n < 8 && starts[i + 1 + n] - starts[i] <= 16'd127)
				n = n + 1;
			j = i + 1 + int'($urandom % n);
			case (ops[i])
				LD_XL_DIR, ADD_XL_DIR, LD_DIR_XL, LDW_DIR_Y:
				begin
					mem[starts[i] + 16'd1] = dir[7:0];
					mem[starts[i] + 16'd2] = dir[15:8];
				end
				JP_IMMD:
				begin
					mem[starts[i] + 16'd1] = starts[j][7:0];
					mem[starts[i] + 16'd2] = starts[j][15:8];
				end
				JR_D, JRZ_D, JRNZ_D, JRC_D, JRNC_D:
					mem[starts[i] + 16'd1] = 8'(starts[j] - starts[i]);
				default: ;
			endcase
		end
		mem[starts[200]] = TRAP;
		for (int i = 0; i < 65536; i++)
			m_mem[i] = mem[i];
		m_x = '0;
		m_y = '0;
		m_c = 1'b0;
		m_z = 1'b0;
		m_n = 1'b0;
		m_pc = RESET_PC;

		repeat (16) @(posedge clk);
		@(negedge clk);
		if (iread_addr !== RESET_PC)
		begin
			$display("FAILED %0t iread_addr expected %h got %h", $time, RESET_PC,
				iread_addr);
			errors = errors + 1;
		end
		if (dwrite.en !== 2'b00)
		begin
			$display("FAILED %0t dwrite.en expected %b got %b", $time, 2'b00, dwrite.en);
			errors = errors + 1;
		end
		if (trap !== 1'b0)
		begin
			$display("FAILED %0t trap expected %b got %b", $time, 1'b0, trap);
			errors = errors + 1;
		end
		reset = 1'b0;
		active = 1'b1;

		// 201 instructions at most, plus a few cycles held in trap
		while (trap_cycles < 5 && cycles < 1000)
			@(negedge clk);
		if (cycles >= 1000)
		begin
			$display("timeout after 1000 cycles, trap was never reached");
			errors = errors + 1;
		end
		@(negedge clk);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
f8_pkg.sv
f8_decode.sv
f8_regfile.sv
f8_alu.sv
f8_flow.sv
f8_core.sv
tb_f8.sv
